// ==== sim.f ====
hw/cache_pkg.sv
hw/mem_pkg.sv
hw/set_ram.sv
hw/lru_table.sv
hw/d_cache.sv
hw/block_memory.sv
hw/dcache_top.sv
test/dcache_assertions.sv
test/tb_dcache.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_dcache
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_dcache.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_dcache: memory load, read sequences, data and
// hit model, compare process
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_dcache;

    logic                              clk;
    logic                              rst;
    logic [cache_pkg::ADDR_W-1:0]      addr;
    logic                              rd;
    logic                              hit;
    logic [cache_pkg::WORD_W-1:0]      rdata;
    logic                              load_we;
    logic [mem_pkg::MEM_IDX_W-1:0]     load_idx;
    logic [cache_pkg::BLOCK_W-1:0]     load_data;

    // copy of everything loaded into the block memory
    cache_pkg::block_t shadow [mem_pkg::MEM_BLOCKS];

    // expected tag state per set
    logic        m_valid [cache_pkg::SETS][2];
    logic [19:0] m_tag   [cache_pkg::SETS][2];
    logic        m_lru   [cache_pkg::SETS];

    // finished reads waiting for the compare process
    logic [31:0] obs_addr_q [$];
    logic [31:0] obs_data_q [$];
    logic        obs_hit_q  [$];
    logic        exp_hit_q  [$];

    integer seed;
    int     errors;
    int     reads;
    int     tests_run;
    int     tests_failed;
    int     err_base;

    dcache_top DUT (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .rd        (rd),
        .hit       (hit),
        .rdata     (rdata),
        .load_we   (load_we),
        .load_idx  (load_idx),
        .load_data (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] make_addr(input logic [19:0] tag, input logic [7:0] set,
                                              input logic [1:0] word, input logic [1:0] byte_off);
        return {tag, set, word, byte_off};
    endfunction

    // memory aliases modulo 16 KiB and the word offset sits in bits 3:2
    function automatic logic [31:0] expected_word(input logic [31:0] a);
        int blk;
        int w;
        blk = int'(a[13:4]);
        w   = int'(a[3:2]);
        return shadow[blk][w];
    endfunction

    // advances the tag model and returns 1 on a predicted hit
    function automatic logic predict_hit(input logic [31:0] a);
        int          s;
        logic [19:0] t;
        logic        found;
        logic        way;
        s     = int'(a[11:4]);
        t     = a[31:12];
        found = 1'b0;
        way   = 1'b0;
        if (m_valid[s][0] && m_tag[s][0] == t) begin
            found = 1'b1;
        end else if (m_valid[s][1] && m_tag[s][1] == t) begin
            found = 1'b1;
            way   = 1'b1;
        end
        if (!found) begin
            // refill goes to the lru way
            way            = m_lru[s];
            m_valid[s][way] = 1'b1;
            m_tag[s][way]   = t;
        end
        // hit and refill both point the bit at the other way
        m_lru[s] = ~way;
        return found;
    endfunction

    task automatic load_memory();
        int i;
        int w;
        for (i = 0; i < mem_pkg::MEM_BLOCKS; i++) begin
            for (w = 0; w < 4; w++) begin
                shadow[i][w] = $random(seed);
            end
            @(posedge clk);
            #1;
            load_we   = 1'b1;
            load_idx  = mem_pkg::mem_idx_t'(i);
            load_data = shadow[i];
        end
        @(posedge clk);
        #1;
        load_we = 1'b0;
    endtask

    // holds the address until hit
    // a hit within two edges counts as a cache hit
    task automatic read_word(input logic [31:0] a);
        int   edges;
        logic seen;
        logic pred;
        pred = predict_hit(a);
        @(posedge clk);
        #1;
        addr  = a;
        rd    = 1'b1;
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges <= mem_pkg::MEM_LATENCY + 10) begin
            @(negedge clk);
            if (hit) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                edges++;
            end
        end
        if (!seen) begin
            errors++;
            $display("timeout: no hit for address %h within %0d cycles", a, edges);
        end else begin
            obs_addr_q.push_back(a);
            obs_data_q.push_back(rdata);
            obs_hit_q.push_back(edges <= 2);
            exp_hit_q.push_back(pred);
            reads++;
        end
    endtask

    task automatic start_test();
        err_base = errors;
    endtask

    // lets the compare process drain before the summary line
    task automatic finish_test(input string name);
        @(posedge clk);
        #1;
        tests_run++;
        if (errors == err_base) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_base);
        end
    endtask

    initial begin : compare_reads
        logic [31:0] a;
        logic [31:0] d;
        logic        h;
        logic        p;
        forever begin
            @(posedge clk);
            while (obs_addr_q.size() > 0) begin
                a = obs_addr_q.pop_front();
                d = obs_data_q.pop_front();
                h = obs_hit_q.pop_front();
                p = exp_hit_q.pop_front();
                if (d !== expected_word(a)) begin
                    errors++;
                    $display("Mismatch at %0t: addr %h rdata %h expected %h",
                             $time, a, d, expected_word(a));
                end
                if (h !== p) begin
                    errors++;
                    $display("Mismatch at %0t: addr %h was a %s, expected a %s",
                             $time, a, h ? "hit" : "miss", p ? "hit" : "miss");
                end
            end
        end
    end

    initial begin : stimulus
        int s;
        int w;
        int n;
        rst          = 1'b1;
        addr         = '0;
        rd           = 1'b0;
        load_we      = 1'b0;
        load_idx     = '0;
        load_data    = '0;
        seed         = 32'h844d;
        errors       = 0;
        reads        = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_base     = 0;
        for (s = 0; s < cache_pkg::SETS; s++) begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
            m_tag[s][0]   = '0;
            m_tag[s][1]   = '0;
            m_lru[s]      = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        load_memory();

        start_test();
        read_word(make_addr(20'h00012, 8'h34, 2'd0, 2'd0));
        for (w = 0; w < 4; w++) begin
            read_word(make_addr(20'h00012, 8'h34, 2'(w), 2'd0));
        end
        finish_test("cold miss then hit");

        // byte offset varies and must not matter
        start_test();
        for (s = 5; s < 8; s++) begin
            for (w = 0; w < 4; w++) begin
                read_word(make_addr(20'h00003, 8'(s), 2'(w), 2'(w)));
            end
            for (w = 0; w < 4; w++) begin
                read_word(make_addr(20'h00003, 8'(s), 2'(w), 2'(3 - w)));
            end
        end
        finish_test("word select");

        start_test();
        read_word(make_addr(20'h00100, 8'h50, 2'd1, 2'd0));
        read_word(make_addr(20'h00201, 8'h50, 2'd2, 2'd0));
        for (n = 0; n < 3; n++) begin
            read_word(make_addr(20'h00100, 8'h50, 2'd1, 2'd0));
            read_word(make_addr(20'h00201, 8'h50, 2'd2, 2'd0));
        end
        finish_test("two ways");

        // x then y then x again, so z takes y's way
        start_test();
        read_word(make_addr(20'h00300, 8'h60, 2'd0, 2'd0));
        read_word(make_addr(20'h00301, 8'h60, 2'd0, 2'd0));
        read_word(make_addr(20'h00300, 8'h60, 2'd3, 2'd0));
        read_word(make_addr(20'h00302, 8'h60, 2'd1, 2'd0));
        read_word(make_addr(20'h00300, 8'h60, 2'd2, 2'd0));
        read_word(make_addr(20'h00301, 8'h60, 2'd0, 2'd0));
        finish_test("lru replacement");

        start_test();
        for (n = 0; n < 2; n++) begin
            for (s = 8'h70; s < 8'h73; s++) begin
                read_word(make_addr(20'h00400, 8'(s), 2'(s), 2'd0));
            end
        end
        finish_test("set isolation");

        // 8 tags over 4 sets where bit 14 aliases in the memory
        start_test();
        for (n = 0; n < 200; n++) begin
            read_word($random(seed) & 32'h0000_703f);
        end
        finish_test("random traffic");

        @(posedge clk);
        #1;
        rd = 1'b0;
        @(posedge clk);
        $display("tests %0d, failed %0d, reads %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, reads, errors, DUT.u_d_cache.u_checks.fail_count);
        if (tests_failed == 0 && errors == 0 && DUT.u_d_cache.u_checks.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== test/dcache_assertions.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch, ready and hit protocol checks for d_cache
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dcache_assertions (
    input logic clk,
    input logic rst,
    input logic rd,
    input logic hit,
    input logic fetch,
    input logic ready
);

    // fetch seen, ready not yet back
    logic pending;

    // failures, read by the testbench at the end
    int fail_count = 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (fetch) begin
            pending <= 1'b1;
        end else if (ready) begin
            pending <= 1'b0;
        end
    end

    fetch_one_cycle: assert property (@(posedge clk) disable iff (rst) fetch |=> !fetch)
        else begin
            $error("fetch high for more than one cycle");
            fail_count++;
        end

    // one miss outstanding at most
    no_second_fetch: assert property (@(posedge clk) disable iff (rst) fetch |-> !pending)
        else begin
            $error("second fetch issued before ready");
            fail_count++;
        end

    hit_needs_rd: assert property (@(posedge clk) disable iff (rst) hit |-> rd)
        else begin
            $error("hit high while rd is low");
            fail_count++;
        end

    ready_needs_fetch: assert property (@(posedge clk) disable iff (rst) ready |-> pending)
        else begin
            $error("ready without a fetch in flight");
            fail_count++;
        end

endmodule

bind d_cache dcache_assertions u_checks (
    .clk   (clk),
    .rst   (rst),
    .rd    (rd),
    .hit   (hit),
    .fetch (fetch),
    .ready (ready)
);

// ==== hw/dcache_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dcache_top: cache plus its backing memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dcache_top (
    input  logic                             clk,
    input  logic                             rst,
    // requester
    input  logic [cache_pkg::ADDR_W-1:0]     addr,
    input  logic                             rd,
    output logic                             hit,
    output logic [cache_pkg::WORD_W-1:0]     rdata,
    // memory load
    input  logic                             load_we,
    input  logic [mem_pkg::MEM_IDX_W-1:0]    load_idx,
    input  logic [cache_pkg::BLOCK_W-1:0]    load_data
);

    // miss path between cache and memory
    logic              fetch;
    mem_pkg::mem_idx_t fetch_idx;
    logic              ready;
    cache_pkg::block_t fill_data;

    d_cache u_d_cache (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .rd        (rd),
        .hit       (hit),
        .rdata     (rdata),
        .fetch     (fetch),
        .fetch_idx (fetch_idx),
        .ready     (ready),
        .fill_data (fill_data)
    );

    // loads bypass the cache, not coherent
    block_memory u_block_memory (
        .clk       (clk),
        .rst       (rst),
        .load_we   (load_we),
        .load_idx  (load_idx),
        .load_data (load_data),
        .fetch     (fetch),
        .fetch_idx (fetch_idx),
        .ready     (ready),
        .fill_data (fill_data)
    );

endmodule

// ==== hw/block_memory.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// block_memory: backing RAM, load port and a
// fixed-latency block fetch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module block_memory (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_we,
    input  mem_pkg::mem_idx_t load_idx,
    input  cache_pkg::block_t load_data,
    input  logic              fetch,
    input  mem_pkg::mem_idx_t fetch_idx,
    output logic              ready,
    output cache_pkg::block_t fill_data
);

    cache_pkg::block_t mem [mem_pkg::MEM_BLOCKS];

    // latency countdown
    logic              busy;
    mem_pkg::mem_cnt_t count;

    // storage and the captured block
    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_idx] <= load_data;
        end
        // block held on fill_data until the next fetch
        if (fetch && !busy) begin
            fill_data <= mem[fetch_idx];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
            ready <= 1'b0;
        end else begin
            ready <= 1'b0;
            if (fetch && !busy) begin
                // start of a fetch
                busy  <= 1'b1;
                count <= mem_pkg::mem_cnt_t'(1);
            end else if (busy) begin
                count <= count + 1'b1;
                // count reaches MEM_LATENCY, one ready pulse
                if (count == mem_pkg::MEM_CNT_LAST) begin
                    busy  <= 1'b0;
                    ready <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/d_cache.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// d_cache: two-way lookup, word select, miss fetch
// and refill of the LRU way
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module d_cache (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [cache_pkg::ADDR_W-1:0]    addr,
    input  logic                            rd,
    output logic                            hit,
    output cache_pkg::word_t                rdata,
    output logic                            fetch,
    output mem_pkg::mem_idx_t               fetch_idx,
    input  logic                            ready,
    input  cache_pkg::block_t               fill_data
);

    // address fields
    logic [cache_pkg::TAG_W-1:0] cur_tag;
    cache_pkg::set_idx_t         cur_set;
    logic [1:0]                  word_sel;

    assign cur_tag  = addr[cache_pkg::TAG_LSB +: cache_pkg::TAG_W];
    assign cur_set  = addr[cache_pkg::SET_LSB +: cache_pkg::SET_W];
    assign word_sel = addr[cache_pkg::WORD_SEL_LSB +: 2];

    // array read side, one per way
    cache_pkg::tag_entry_t tag_rd  [2];
    cache_pkg::block_t     data_rd [2];
    logic [1:0]            way_we;
    logic [1:0]            way_hit;

    // registered copy of the set the arrays just read
    cache_pkg::set_idx_t set_q;

    // outstanding miss
    logic                        in_flight;
    logic                        refill_q;
    logic [cache_pkg::TAG_W-1:0] miss_tag;
    cache_pkg::set_idx_t         miss_set;

    logic                refill;
    logic                victim_way;
    logic                set_match;
    logic                miss;
    cache_pkg::set_idx_t lru_set;
    cache_pkg::block_t   hit_block;

    assign refill = ready & in_flight;

    for (genvar w = 0; w < 2; w++) begin : g_way
        // refill targets the victim way only
        assign way_we[w] = refill & (victim_way == w);

        set_ram #(
            .entry_t (cache_pkg::tag_entry_t)
        ) u_tag_ram (
            .clk     (clk),
            .rst     (rst),
            .rd_idx  (cur_set),
            .we      (way_we[w]),
            .wr_idx  (miss_set),
            .wr_data ({1'b1, miss_tag}),
            .rd_data (tag_rd[w])
        );

        set_ram #(
            .entry_t (cache_pkg::block_t)
        ) u_data_ram (
            .clk     (clk),
            .rst     (rst),
            .rd_idx  (cur_set),
            .we      (way_we[w]),
            .wr_idx  (miss_set),
            .wr_data (fill_data),
            .rd_data (data_rd[w])
        );

        assign way_hit[w] = set_match & tag_rd[w].valid & (tag_rd[w].tag == cur_tag);
    end

    // entries belong to the current set only when the copy agrees
    assign set_match = (set_q == cur_set);
    assign hit       = rd & (|way_hit);

    // word from the hitting way
    assign hit_block = way_hit[1] ? data_rd[1] : data_rd[0];
    assign rdata     = hit_block[word_sel];

    // no decision in the cycle after a refill, arrays still hold old data
    assign miss = rd & set_match & ~(|way_hit) & ~in_flight & ~refill_q;

    // refill updates the LRU bit of the missed set
    assign lru_set = refill ? miss_set : cur_set;

    lru_table u_lru (
        .clk        (clk),
        .rst        (rst),
        .set        (lru_set),
        .hit        (hit),
        .hit_way    (way_hit[1]),
        .refill     (refill),
        .refill_way (victim_way),
        .victim_way (victim_way)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            set_q     <= '0;
            fetch     <= 1'b0;
            in_flight <= 1'b0;
            refill_q  <= 1'b0;
        end else begin
            set_q    <= cur_set;
            refill_q <= refill;
            // one-cycle pulse, in_flight blocks a repeat
            fetch    <= miss;
            if (miss) begin
                in_flight <= 1'b1;
            end else if (refill) begin
                in_flight <= 1'b0;
            end
        end
    end

    // miss address, kept for the refill writes
    always_ff @(posedge clk) begin
        if (miss) begin
            miss_tag  <= cur_tag;
            miss_set  <= cur_set;
            fetch_idx <= addr[mem_pkg::MEM_IDX_LSB +: mem_pkg::MEM_IDX_W];
        end
    end

endmodule

// ==== hw/lru_table.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lru_table: one replacement bit per set
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lru_table (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::set_idx_t set,
    input  logic                hit,
    input  logic                hit_way,
    input  logic                refill,
    input  logic                refill_way,
    output logic                victim_way
);

    // bit names the way to replace next
    logic [cache_pkg::SETS-1:0] lru;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lru <= '0;
        end else if (refill) begin
            // point away from the way just filled
            lru[set] <= ~refill_way;
        end else if (hit) begin
            // the other way becomes the victim
            lru[set] <= ~hit_way;
        end
    end

    // combinational lookup for the current set
    assign victim_way = lru[set];

endmodule

// ==== hw/set_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// set_ram: one payload per set, registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module set_ram #(
    parameter type entry_t = cache_pkg::tag_entry_t
) (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::set_idx_t rd_idx,
    input  logic                we,
    input  cache_pkg::set_idx_t wr_idx,
    input  entry_t              wr_data,
    output entry_t              rd_data
);

    // one entry per set
    entry_t mem [cache_pkg::SETS];

    // read and write share the edge
    // a write to the set being read shows on the next read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // clearing every entry invalidates the way
            for (int i = 0; i < cache_pkg::SETS; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (we) begin
                mem[wr_idx] <= wr_data;
            end
            // old contents on a same-set write
            rd_data <= mem[rd_idx];
        end
    end

endmodule

// ==== hw/mem_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// backing memory size, fetch latency, block index
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mem_pkg;

    // cycles from fetch to ready
    localparam int MEM_LATENCY = 20;

    // modelled blocks; addresses alias modulo 16 KiB
    localparam int MEM_BLOCKS  = 1024;
    localparam int MEM_IDX_W   = 10;
    localparam int MEM_IDX_LSB = 4;

    typedef logic [MEM_IDX_W-1:0] mem_idx_t;

    // latency counter
    localparam int MEM_CNT_W = $clog2(MEM_LATENCY + 1);

    typedef logic [MEM_CNT_W-1:0] mem_cnt_t;

    // last count before ready is raised
    localparam mem_cnt_t MEM_CNT_LAST = mem_cnt_t'(MEM_LATENCY - 1);

endpackage

// ==== hw/cache_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache geometry, address field positions and the
// payload types of the tag and data arrays
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cache_pkg;

    // byte address from the requester
    localparam int ADDR_W = 32;

    // tag field, bits 31:12
    localparam int TAG_W   = 20;
    localparam int TAG_LSB = 12;

    // set index, bits 11:4
    localparam int SET_W   = 8;
    localparam int SET_LSB = 4;
    localparam int SETS    = 1 << SET_W;

    // word offset, bits 3:2 (bits 1:0 are the byte offset, ignored)
    localparam int WORD_SEL_LSB = 2;

    // block layout
    localparam int WORD_W          = 32;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int BLOCK_W         = WORD_W * WORDS_PER_BLOCK;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [SET_W-1:0]  set_idx_t;

    // one entry of a tag array
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    // word 0 sits in the low bits
    typedef logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] block_t;

endpackage
